//--- list.f
+incdir+verilog
verilog/aib_adapt_pkg.sv
verilog/aib_avmm_adapt_csr.sv
verilog/aib_lane_distrib.sv
verilog/aib_lane_adapt.sv
verilog/aib_lane_collect.sv
verilog/aib_adapt_top.sv
verification/aib_adapt_tb.sv

//--- run.sh
#!/bin/sh
# Builds the AIB adapter testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -j 0 -f list.f --top-module aib_adapt_tb -o aib_adapt_sim
status=$?
if [ $status -ne 0 ]; then
   echo "Verilator build failed"
   exit $status
fi

./obj_dir/aib_adapt_sim
status=$?
if [ $status -ne 0 ]; then
   echo "Simulation failed"
   exit $status
fi

exit 0

//--- verification/aib_adapt_tb.sv
/*
 * AIB data-path adapter testbench
 * Register access, transformed word streams and credit back-pressure
 */
`timescale 1ns/10ps
`default_nettype none

`include "aib_adapt_defs.svh"

module aib_adapt_tb;

   import aib_adapt_pkg::*;

   localparam int TIMEOUT = 400;
   // Output register, full lanes and the input buffer
   localparam int HOLD_WORDS = `AIB_OUT_CREDITS + `AIB_NUM_LANES * `AIB_LANE_DEPTH
                               + `AIB_IN_CREDITS;

   logic        clk = 1'b0;
   logic        reset_n;
   avmm_addr_t  address;
   avmm_data_t  writedata;
   avmm_be_t    byteenable;
   logic        read;
   logic        write;
   logic        in_valid;
   aib_word_t   in_data;
   logic        out_credit;
   avmm_data_t  readdata;
   logic        readdatavalid;
   logic        in_credit;
   logic        out_valid;
   aib_word_t   out_data;

   integer      seed;
   string       test_name;
   aib_word_t   exp_q [$];
   avmm_data_t  shadow [8];
   avmm_addr_t  half_addr [8] = '{`AIB_ADDR_RX0_LO, `AIB_ADDR_RX0_HI, `AIB_ADDR_RX1_LO,
                                  `AIB_ADDR_RX1_HI, `AIB_ADDR_TX0_LO, `AIB_ADDR_TX0_HI,
                                  `AIB_ADDR_TX1_LO, `AIB_ADDR_TX1_HI};
   avmm_data_t  rd_word;
   int          words_sent;
   int          credits_back;
   int          rx_count;
   int          credits_returned;
   int          rx_base;
   int          waited;
   logic        sink_hold;
   logic        sink_pause_en;

   aib_adapt_top aib_adapt_top_i (
      .clk           (clk),
      .reset_n       (reset_n),
      .address       (address),
      .writedata     (writedata),
      .byteenable    (byteenable),
      .read          (read),
      .write         (write),
      .in_valid      (in_valid),
      .in_data       (in_data),
      .out_credit    (out_credit),
      .readdata      (readdata),
      .readdatavalid (readdatavalid),
      .in_credit     (in_credit),
      .out_valid     (out_valid),
      .out_data      (out_data)
   );

   always #4 clk = ~clk;

   task automatic report_failure(input string msg);
      $display("RESULT: FAIL");
      $fatal(1, "%s", msg);
   endtask

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      assert (actual === expected) else begin
         report_failure($sformatf("Fail %s expected %h actual %h", name, expected, actual));
      end
   endtask

   function automatic aib_word_t rotate_left(input aib_word_t x, input int n);
      aib_word_t y;
      y = x;
      for (int i = 0; i < n; i++) begin
         y = {y[30:0], y[31]};
      end
      return y;
   endfunction

   function automatic aib_word_t rotate_right(input aib_word_t x, input int n);
      aib_word_t y;
      y = x;
      for (int i = 0; i < n; i++) begin
         y = {y[0], y[31:1]};
      end
      return y;
   endfunction

   // Reference transform of one input word through a lane
   function automatic aib_word_t expected_out(input aib_word_t d);
      aib_word_t t;
      t = rotate_left(d ^ {shadow[5], shadow[4]}, int'(shadow[6][4:0]));
      return rotate_right(t, int'(shadow[2][4:0])) ^ {shadow[1], shadow[0]};
   endfunction

   // Byte 0 of the bus goes to the even byte of the half
   task automatic write_half(input int h, input avmm_data_t d, input avmm_be_t be);
      address    = half_addr[h];
      writedata  = d;
      byteenable = be;
      write      = 1'b1;
      if (be[0]) begin
         shadow[h][7:0] = d[7:0];
      end
      if (be[1]) begin
         shadow[h][15:8] = d[15:8];
      end
      @(posedge clk);
      #1;
      write = 1'b0;
   endtask

   task automatic read_half(input avmm_addr_t a, output avmm_data_t d);
      int n;
      n = 0;
      check_value("readdatavalid before read", 32'd0, 32'(readdatavalid));
      address = a;
      read    = 1'b1;
      @(posedge clk);
      #1;
      read = 1'b0;
      while (!readdatavalid) begin
         n++;
         if (n > 8) begin
            report_failure("timeout waiting for readdatavalid after a read");
         end
         @(posedge clk);
         #1;
      end
      check_value("readdatavalid latency", 32'd0, 32'(n));
      d = readdata;
      @(posedge clk);
      #1;
      check_value("readdatavalid pulse", 32'd0, 32'(readdatavalid));
      check_value("idle readdata", 32'd0, 32'(readdata));
   endtask

   task automatic send_word(input aib_word_t w);
      int n;
      n = 0;
      while (`AIB_IN_CREDITS - words_sent + credits_back <= 0) begin
         @(posedge clk);
         #1;
         n++;
         if (n > TIMEOUT) begin
            report_failure("timeout waiting for an input credit");
         end
      end
      exp_q.push_back(expected_out(w));
      in_valid = 1'b1;
      in_data  = w;
      words_sent++;
      @(posedge clk);
      #1;
      in_valid = 1'b0;
   endtask

   task automatic run_stream(input int count);
      aib_word_t stim_q [$];
      for (int i = 0; i < count; i++) begin
         stim_q.push_back($random(seed));
      end
      foreach (stim_q[i]) begin
         send_word(stim_q[i]);
      end
   endtask

   task automatic wait_idle();
      int n;
      n = 0;
      while (exp_q.size() != 0 || rx_count != credits_returned || credits_back != words_sent) begin
         @(posedge clk);
         #1;
         n++;
         if (n > TIMEOUT) begin
            report_failure("timeout waiting for the datapath to drain");
         end
      end
      repeat (3) @(posedge clk);
      #1;
   endtask

   // Checks output order and counts input credits at each clock edge
   task automatic watch_outputs();
      forever begin
         @(posedge clk);
         if (reset_n) begin
            if (in_credit) begin
               credits_back++;
            end
            assert (credits_back <= words_sent) else begin
               report_failure("more in_credit pulses than words sent");
            end
            assert (`AIB_IN_CREDITS - words_sent + credits_back >= 0) else begin
               report_failure("sender went below zero input credits");
            end
            if (out_valid) begin
               if (exp_q.size() == 0) begin
                  report_failure("out_valid seen with no word expected");
               end else begin
                  check_value(test_name, exp_q.pop_front(), out_data);
                  rx_count++;
               end
            end
         end
      end
   endtask

   // Sink returns one credit per received word with occasional pauses
   task automatic return_credits();
      forever begin
         @(posedge clk);
         #1;
         out_credit = 1'b0;
         if (reset_n && !sink_hold && rx_count > credits_returned) begin
            if (!sink_pause_en || ($random(seed) & 3) != 0) begin
               out_credit = 1'b1;
               credits_returned++;
            end
         end
      end
   endtask

   initial begin
      seed             = 32'h1140;
      reset_n          = 1'b0;
      address          = '0;
      writedata        = '0;
      byteenable       = '0;
      read             = 1'b0;
      write            = 1'b0;
      in_valid         = 1'b0;
      in_data          = '0;
      out_credit       = 1'b0;
      words_sent       = 0;
      credits_back     = 0;
      rx_count         = 0;
      credits_returned = 0;
      sink_hold        = 1'b0;
      sink_pause_en    = 1'b0;
      test_name        = "reset";
      foreach (shadow[i]) begin
         shadow[i] = '0;
      end
      fork
         watch_outputs();
         return_credits();
      join_none
      repeat (8) @(posedge clk);
      #1;
      reset_n = 1'b1;

      check_value("reset in_credit", 32'd0, 32'(in_credit));
      check_value("reset out_valid", 32'd0, 32'(out_valid));
      for (int h = 0; h < 8; h++) begin
         read_half(half_addr[h], rd_word);
         check_value("reset register", 32'(shadow[h]), 32'(rd_word));
      end

      // Byte enables step from both bytes through upper and lower to none
      for (int h = 0; h < 8; h++) begin
         for (int k = 0; k < 4; k++) begin
            write_half(h, avmm_data_t'($random(seed)), avmm_be_t'(3 - k));
            read_half(half_addr[h], rd_word);
            check_value("byte merge", 32'(shadow[h]), 32'(rd_word));
         end
      end
      read_half(7'h00, rd_word);
      check_value("unmapped read", 32'd0, 32'(rd_word));
      read_half(7'h0c, rd_word);
      check_value("unmapped read", 32'd0, 32'(rd_word));

      test_name = "zero transform";
      for (int h = 0; h < 8; h++) begin
         write_half(h, 16'h0000, 2'b11);
      end
      sink_pause_en = 1'b1;
      run_stream(40);
      wait_idle();

      test_name = "random transform";
      for (int r = 0; r < 3; r++) begin
         for (int h = 0; h < 8; h++) begin
            write_half(h, avmm_data_t'($random(seed)), 2'b11);
         end
         run_stream(24);
         wait_idle();
      end

      // Held output credits let every stage fill before the stream resumes
      test_name     = "back pressure";
      sink_pause_en = 1'b0;
      sink_hold     = 1'b1;
      rx_base       = rx_count;
      run_stream(HOLD_WORDS);
      waited = 0;
      while (credits_back != words_sent - `AIB_IN_CREDITS) begin
         @(posedge clk);
         #1;
         waited++;
         if (waited > TIMEOUT) begin
            report_failure("timeout waiting for the lanes to fill");
         end
      end
      repeat (20) @(posedge clk);
      #1;
      check_value("held output words", `AIB_OUT_CREDITS, 32'(rx_count - rx_base));
      check_value("held input credits", 32'(words_sent - `AIB_IN_CREDITS), 32'(credits_back));
      check_value("held out_valid", 32'd0, 32'(out_valid));
      sink_hold = 1'b0;
      wait_idle();

      $display("RESULT: PASS");
      $finish;
   end

endmodule

`default_nettype wire

//--- verilog/aib_adapt_top.sv
/*
 * AIB data-path adapter top level
 * Register block, distributor, lane adapters and collector
 */
`timescale 1ns/10ps
`default_nettype none

`include "aib_adapt_defs.svh"

module aib_adapt_top (
   input  wire                        clk,
   input  wire                        reset_n,
   input  aib_adapt_pkg::avmm_addr_t  address,
   input  aib_adapt_pkg::avmm_data_t  writedata,
   input  aib_adapt_pkg::avmm_be_t    byteenable,
   input  wire                        read,
   input  wire                        write,
   input  wire                        in_valid,
   input  aib_adapt_pkg::aib_word_t   in_data,
   input  wire                        out_credit,
   output aib_adapt_pkg::avmm_data_t  readdata,
   output logic                       readdatavalid,
   output logic                       in_credit,
   output logic                       out_valid,
   output aib_adapt_pkg::aib_word_t   out_data
);

   import aib_adapt_pkg::*;

   // Transform settings
   aib_word_t                        rx_0;
   aib_word_t                        rx_1;
   aib_word_t                        tx_0;
   aib_word_t                        tx_1;

   // Lane side of distributor and collector
   logic [`AIB_NUM_LANES-1:0]        lane_push;
   aib_word_t                        lane_data;
   logic [`AIB_NUM_LANES-1:0]        lane_credit;
   logic [`AIB_NUM_LANES-1:0]        lane_valid;
   aib_word_t [`AIB_NUM_LANES-1:0]   lane_rdata;
   logic [`AIB_NUM_LANES-1:0]        lane_pop;

   aib_avmm_adapt_csr aib_avmm_adapt_csr_i (
      .clk           (clk),
      .reset_n       (reset_n),
      .address       (address),
      .writedata     (writedata),
      .byteenable    (byteenable),
      .read          (read),
      .write         (write),
      .readdata      (readdata),
      .readdatavalid (readdatavalid),
      .rx_0          (rx_0),
      .rx_1          (rx_1),
      .tx_0          (tx_0),
      .tx_1          (tx_1)
   );

   aib_lane_distrib aib_lane_distrib_i (
      .clk         (clk),
      .reset_n     (reset_n),
      .in_valid    (in_valid),
      .in_data     (in_data),
      .lane_credit (lane_credit),
      .in_credit   (in_credit),
      .lane_push   (lane_push),
      .lane_data   (lane_data)
   );

   for (genvar g = 0; g < `AIB_NUM_LANES; g++) begin : g_lane
      aib_lane_adapt aib_lane_adapt_i (
         .clk     (clk),
         .reset_n (reset_n),
         .push    (lane_push[g]),
         .wdata   (lane_data),
         .pop     (lane_pop[g]),
         .tx_mask (tx_0),
         .tx_rot  (tx_1),
         .rx_mask (rx_0),
         .rx_rot  (rx_1),
         .valid   (lane_valid[g]),
         .rdata   (lane_rdata[g]),
         .credit  (lane_credit[g])
      );
   end

   aib_lane_collect aib_lane_collect_i (
      .clk        (clk),
      .reset_n    (reset_n),
      .lane_valid (lane_valid),
      .lane_rdata (lane_rdata),
      .out_credit (out_credit),
      .lane_pop   (lane_pop),
      .out_valid  (out_valid),
      .out_data   (out_data)
   );

endmodule

`default_nettype wire

//--- verilog/aib_lane_collect.sv
/*
 * AIB lane collector
 * Drains the lanes in round-robin order into a registered output
 * while output credits remain
 */
`timescale 1ns/10ps
`default_nettype none

`include "aib_adapt_defs.svh"

module aib_lane_collect (
   input  wire                                             clk,
   input  wire                                             reset_n,
   input  wire [`AIB_NUM_LANES-1:0]                        lane_valid,
   input  aib_adapt_pkg::aib_word_t [`AIB_NUM_LANES-1:0]   lane_rdata,
   input  wire                                             out_credit,
   output logic [`AIB_NUM_LANES-1:0]                       lane_pop,
   output logic                                            out_valid,
   output aib_adapt_pkg::aib_word_t                        out_data
);

   import aib_adapt_pkg::*;

   lane_idx_t     rr_ptr;
   credit_cnt_t   out_cnt;
   logic          pop_en;

   // Same lane order as the distributor keeps words in sequence
   assign pop_en = lane_valid[rr_ptr] && (out_cnt != '0);

   always_comb begin
      lane_pop         = '0;
      lane_pop[rr_ptr] = pop_en;
   end

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         rr_ptr    <= '0;
         out_cnt   <= credit_cnt_t'(`AIB_OUT_CREDITS);
         out_valid <= 1'b0;
      end else begin
         out_valid <= pop_en;
         if (pop_en) begin
            rr_ptr <= rr_ptr + lane_idx_t'(1);
         end
         // Sink returns a credit, each output word spends one
         out_cnt <= out_cnt + credit_cnt_t'(out_credit) - credit_cnt_t'(pop_en);
      end
   end

   always_ff @(posedge clk) begin
      if (pop_en) begin
         out_data <= lane_rdata[rr_ptr];
      end
   end

endmodule

`default_nettype wire

//--- verilog/aib_lane_adapt.sv
/*
 * AIB lane adapter
 * Lane buffer that applies the transmit transform on push and the
 * receive transform at its head, returning a credit per pop
 */
`timescale 1ns/10ps
`default_nettype none

`include "aib_adapt_defs.svh"

module aib_lane_adapt (
   input  wire                        clk,
   input  wire                        reset_n,
   input  wire                        push,
   input  aib_adapt_pkg::aib_word_t   wdata,
   input  wire                        pop,
   input  aib_adapt_pkg::aib_word_t   tx_mask,
   input  aib_adapt_pkg::aib_word_t   tx_rot,
   input  aib_adapt_pkg::aib_word_t   rx_mask,
   input  aib_adapt_pkg::aib_word_t   rx_rot,
   output logic                       valid,
   output aib_adapt_pkg::aib_word_t   rdata,
   output logic                       credit
);

   import aib_adapt_pkg::*;

   localparam int PTR_W = $clog2(`AIB_LANE_DEPTH);

   aib_word_t          mem [`AIB_LANE_DEPTH];
   logic [PTR_W-1:0]   wr_ptr;
   logic [PTR_W-1:0]   rd_ptr;
   credit_cnt_t        fill;
   rot_amt_t           tx_amt;
   rot_amt_t           rx_amt;

   function automatic aib_word_t rot_left(aib_word_t x, rot_amt_t r);
      logic [63:0] dbl;
      dbl = {x, x} << r;
      return dbl[63:32];
   endfunction

   function automatic aib_word_t rot_right(aib_word_t x, rot_amt_t r);
      logic [63:0] dbl;
      dbl = {x, x} >> r;
      return dbl[31:0];
   endfunction

   // Only the low 5 bits of a rotate register count
   assign tx_amt = tx_rot[4:0];
   assign rx_amt = rx_rot[4:0];

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         fill   <= '0;
         credit <= 1'b0;
      end else begin
         credit <= pop;
         if (push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         fill <= fill + credit_cnt_t'(push) - credit_cnt_t'(pop);
      end
   end

   // Transmit transform, mask then rotate left
   always_ff @(posedge clk) begin
      if (push) begin
         mem[wr_ptr] <= rot_left(wdata ^ tx_mask, tx_amt);
      end
   end

   assign valid = (fill != '0);

   // Receive transform, rotate right then mask
   assign rdata = rot_right(mem[rd_ptr], rx_amt) ^ rx_mask;

endmodule

`default_nettype wire

//--- verilog/aib_lane_distrib.sv
/*
 * AIB lane distributor
 * Buffers incoming words under upstream credits and deals them
 * round-robin to the lanes while each lane has room
 */
`timescale 1ns/10ps
`default_nettype none

`include "aib_adapt_defs.svh"

module aib_lane_distrib (
   input  wire                           clk,
   input  wire                           reset_n,
   input  wire                           in_valid,
   input  aib_adapt_pkg::aib_word_t      in_data,
   input  wire [`AIB_NUM_LANES-1:0]      lane_credit,
   output logic                          in_credit,
   output logic [`AIB_NUM_LANES-1:0]     lane_push,
   output aib_adapt_pkg::aib_word_t      lane_data
);

   import aib_adapt_pkg::*;

   localparam int PTR_W = $clog2(`AIB_IN_CREDITS);

   // Input buffer sized to the upstream credits
   aib_word_t           in_buf [`AIB_IN_CREDITS];
   logic [PTR_W-1:0]    wr_ptr;
   logic [PTR_W-1:0]    rd_ptr;
   credit_cnt_t         in_cnt;
   lane_idx_t           rr_ptr;
   credit_cnt_t         lane_cnt [`AIB_NUM_LANES];
   logic                fwd;

   // Head word moves on when the pointed lane has a free slot
   assign fwd = (in_cnt != '0) && (lane_cnt[rr_ptr] != '0);

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         wr_ptr    <= '0;
         rd_ptr    <= '0;
         in_cnt    <= '0;
         rr_ptr    <= '0;
         in_credit <= 1'b0;
         lane_push <= '0;
         for (int i = 0; i < `AIB_NUM_LANES; i++) begin
            lane_cnt[i] <= credit_cnt_t'(`AIB_LANE_DEPTH);
         end
      end else begin
         in_credit <= fwd;
         lane_push <= '0;
         if (in_valid) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (fwd) begin
            lane_push[rr_ptr] <= 1'b1;
            rd_ptr            <= rd_ptr + 1'b1;
            rr_ptr            <= rr_ptr + lane_idx_t'(1);
         end
         in_cnt <= in_cnt + credit_cnt_t'(in_valid) - credit_cnt_t'(fwd);
         // One slot back per lane pop, one taken per push
         for (int i = 0; i < `AIB_NUM_LANES; i++) begin
            lane_cnt[i] <= lane_cnt[i] + credit_cnt_t'(lane_credit[i])
                           - credit_cnt_t'(fwd && (rr_ptr == lane_idx_t'(i)));
         end
      end
   end

   // Payload storage
   always_ff @(posedge clk) begin
      if (in_valid) begin
         in_buf[wr_ptr] <= in_data;
      end
      if (fwd) begin
         lane_data <= in_buf[rd_ptr];
      end
   end

endmodule

`default_nettype wire

//--- verilog/aib_avmm_adapt_csr.sv
/*
 * AIB adapter register block
 * Holds receive and transmit mask and rotate settings behind a 16-bit
 * AVMM bus with byte enables and one-cycle read data
 */
`timescale 1ns/10ps
`default_nettype none

`include "aib_adapt_defs.svh"

module aib_avmm_adapt_csr (
   input  wire                        clk,
   input  wire                        reset_n,
   input  aib_adapt_pkg::avmm_addr_t  address,
   input  aib_adapt_pkg::avmm_data_t  writedata,
   input  aib_adapt_pkg::avmm_be_t    byteenable,
   input  wire                        read,
   input  wire                        write,
   output aib_adapt_pkg::avmm_data_t  readdata,
   output logic                       readdatavalid,
   output aib_adapt_pkg::aib_word_t   rx_0,
   output aib_adapt_pkg::aib_word_t   rx_1,
   output aib_adapt_pkg::aib_word_t   tx_0,
   output aib_adapt_pkg::aib_word_t   tx_1
);

   import aib_adapt_pkg::*;

   // Eight 16-bit halves, even index is the low half of a register
   avmm_data_t [7:0]  half_q;
   logic [2:0]        half_sel;
   logic              addr_hit;
   logic [15:0]       byte_we;
   avmm_data_t        rdata_comb;

   // Address decode into a half index
   always_comb begin
      addr_hit = 1'b1;
      half_sel = 3'd0;
      case (address)
         `AIB_ADDR_RX0_LO: half_sel = 3'd0;
         `AIB_ADDR_RX0_HI: half_sel = 3'd1;
         `AIB_ADDR_RX1_LO: half_sel = 3'd2;
         `AIB_ADDR_RX1_HI: half_sel = 3'd3;
         `AIB_ADDR_TX0_LO: half_sel = 3'd4;
         `AIB_ADDR_TX0_HI: half_sel = 3'd5;
         `AIB_ADDR_TX1_LO: half_sel = 3'd6;
         `AIB_ADDR_TX1_HI: half_sel = 3'd7;
         default:          addr_hit = 1'b0;
      endcase
   end

   // Per-byte write enables, two bits per half
   always_comb begin
      byte_we = '0;
      if (write && addr_hit) begin
         byte_we[2*half_sel +: 2] = byteenable;
      end
   end

   // Byte 0 of the bus lands in the even byte of the half
   always_ff @(posedge clk) begin
      if (!reset_n) begin
         half_q <= '0;
      end else begin
         for (int i = 0; i < 8; i++) begin
            if (byte_we[2*i]) begin
               half_q[i][7:0] <= writedata[7:0];
            end
            if (byte_we[2*i+1]) begin
               half_q[i][15:8] <= writedata[15:8];
            end
         end
      end
   end

   assign rx_0 = {half_q[1], half_q[0]};
   assign rx_1 = {half_q[3], half_q[2]};
   assign tx_0 = {half_q[5], half_q[4]};
   assign tx_1 = {half_q[7], half_q[6]};

   // Unmapped addresses and idle cycles give zero
   always_comb begin
      rdata_comb = '0;
      if (read && addr_hit) begin
         rdata_comb = half_q[half_sel];
      end
   end

   // Read data and its valid follow read by one cycle
   always_ff @(posedge clk) begin
      if (!reset_n) begin
         readdata      <= '0;
         readdatavalid <= 1'b0;
      end else begin
         readdata      <= rdata_comb;
         readdatavalid <= read;
      end
   end

endmodule

`default_nettype wire

//--- verilog/aib_adapt_pkg.sv
/*
 * AIB adapter types
 * Vector typedefs shared by the register block and the datapath
 */
`default_nettype none

package aib_adapt_pkg;

   // Datapath word
   typedef logic [31:0] aib_word_t;

   // AVMM bus fields
   typedef logic [15:0] avmm_data_t;
   typedef logic [6:0]  avmm_addr_t;
   typedef logic [1:0]  avmm_be_t;

   // Round-robin lane number
   typedef logic [1:0]  lane_idx_t;

   // Low bits of a rotate register
   typedef logic [4:0]  rot_amt_t;

   // Holds 0 up to the largest credit or fill count
   typedef logic [2:0]  credit_cnt_t;

endpackage

`default_nettype wire

//--- verilog/aib_adapt_defs.svh
/*
 * AIB adapter sizes and CSR address map
 * Lane count, buffer depths, credit counts and half-register addresses
 */
`ifndef AIB_ADAPT_DEFS_SVH
`define AIB_ADAPT_DEFS_SVH

// Datapath sizing
`define AIB_NUM_LANES      4
`define AIB_LANE_DEPTH     4
`define AIB_IN_CREDITS     2
`define AIB_OUT_CREDITS    4

// Half-register word addresses, low half then high half
`define AIB_ADDR_RX0_LO    7'h08
`define AIB_ADDR_RX0_HI    7'h0a
`define AIB_ADDR_RX1_LO    7'h10
`define AIB_ADDR_RX1_HI    7'h12
`define AIB_ADDR_TX0_LO    7'h18
`define AIB_ADDR_TX0_HI    7'h1a
`define AIB_ADDR_TX1_LO    7'h1c
`define AIB_ADDR_TX1_HI    7'h1e

`endif
